//--- cpu8.f
+incdir+src
src/cpu8_pkg.sv
src/program_ram.sv
src/axi_lite_prog_loader.sv
src/cpu_core.sv
src/cpu8_top.sv
dv/tb_cpu8.sv

//--- dv/tb_cpu8.sv
// directed testbench for cpu8_top, loads programs over AXI4-Lite and checks the output port
`default_nettype none

`include "cpu8_macros.svh"

module tb_cpu8;

  localparam int TIMEOUT_CYCLES = 200;

  logic                        clk;
  logic                        reset;
  logic                        s_awvalid;
  logic                        s_awready;
  logic [`CPU8_AXI_ADDR_W-1:0] s_awaddr;
  logic                        s_wvalid;
  logic                        s_wready;
  logic [`CPU8_DATA_W-1:0]     s_wdata;
  logic                        s_bvalid;
  logic                        s_bready;
  cpu8_pkg::axi_resp_e         s_bresp;
  logic                        run;
  logic [`CPU8_DATA_W-1:0]     in_data;
  logic [`CPU8_DATA_W-1:0]     out_data;
  logic                        out_valid;

  int error_count;
  int timeout_count;

  // program image, also read by the reference model
  logic [`CPU8_DATA_W-1:0] prog [0:`CPU8_PROG_DEPTH-1];
  logic [`CPU8_DATA_W-1:0] exp_q [$];

  cpu8_top dut (
    .clk       (clk),
    .reset     (reset),
    .s_awvalid (s_awvalid),
    .s_awready (s_awready),
    .s_awaddr  (s_awaddr),
    .s_wvalid  (s_wvalid),
    .s_wready  (s_wready),
    .s_wdata   (s_wdata),
    .s_bvalid  (s_bvalid),
    .s_bready  (s_bready),
    .s_bresp   (s_bresp),
    .run       (run),
    .in_data   (in_data),
    .out_data  (out_data),
    .out_valid (out_valid)
  );

  always #5 clk = ~clk;

  ////////////////////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////////////////////

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      error_count++;
      $display("[FAIL] %0t %s got 0x%0h expected 0x%0h", $time, name, got, exp);
    end
  endtask

  function automatic logic [`CPU8_DATA_W-1:0] instr(input logic [`CPU8_OPC_W-1:0] op,
                                                    input logic [`CPU8_OPD_W-1:0] opd);
    return {op, opd};
  endfunction

  // two nibble loads that assemble one register value
  function automatic void place_byte_load(input int at, input logic [3:0] op_lo,
                                          input logic [3:0] op_hi, input logic [7:0] value);
    prog[at]   = instr(op_lo, value[3:0]);
    prog[at+1] = instr(op_hi, value[7:4]);
  endfunction

  // reference model, runs the image from the reset state and queues the outputs
  function automatic void model_outputs(input int n_outs);
    logic [7:0] a;
    logic [7:0] b;
    logic [7:0] c;
    logic [3:0] pc;
    logic [3:0] op;
    logic [3:0] opd;
    int         steps;
    a = '0;
    b = '0;
    c = '0;
    pc = '0;
    steps = 0;
    exp_q.delete();
    while (exp_q.size() < n_outs && steps < 512) begin
      op  = prog[pc][7:4];
      opd = prog[pc][3:0];
      case (op)
        cpu8_pkg::OP_LDA_LO: a[3:0] = opd;
        cpu8_pkg::OP_LDA_HI: a[7:4] = opd;
        cpu8_pkg::OP_LDB_LO: b[3:0] = opd;
        cpu8_pkg::OP_LDB_HI: b[7:4] = opd;
        cpu8_pkg::OP_LDC_LO: c[3:0] = opd;
        cpu8_pkg::OP_LDC_HI: c[7:4] = opd;
        cpu8_pkg::OP_ADD:    c = a + b;
        cpu8_pkg::OP_SUB:    c = a - b;
        cpu8_pkg::OP_MUL:    c = a * b;
        cpu8_pkg::OP_OUT: begin
          if (opd == 4'd0) exp_q.push_back(a);
          else if (opd == 4'd1) exp_q.push_back(b);
          else if (opd == 4'd2) exp_q.push_back(c);
        end
        cpu8_pkg::OP_IN: begin
          if (opd == 4'd0) a = in_data;
          else if (opd == 4'd1) b = in_data;
          else if (opd == 4'd2) c = in_data;
        end
        default: ;
      endcase
      pc = pc + 4'd1;
      steps++;
    end
  endfunction

  task automatic reset_dut();
    @(negedge clk);
    reset     = 1'b1;
    run       = 1'b0;
    s_awvalid = 1'b0;
    s_wvalid  = 1'b0;
    repeat (16) @(negedge clk);
    reset = 1'b0;
    check_value("s_awready after reset", s_awready, 1'b1);
    check_value("s_wready after reset", s_wready, 1'b1);
    check_value("s_bvalid after reset", s_bvalid, 1'b0);
    check_value("out_valid after reset", out_valid, 1'b0);
    for (int i = 0; i < `CPU8_PROG_DEPTH; i++) begin
      prog[i] = instr(cpu8_pkg::OP_NOP, 4'd0);
    end
  endtask

  // AW and W go up together, each drops after its own handshake
  task automatic axi_write(input logic [3:0] addr, input logic [7:0] data);
    bit aw_go;
    bit w_go;
    int cycles;
    cycles    = 0;
    @(negedge clk);
    s_awaddr  = addr;
    s_wdata   = data;
    s_awvalid = 1'b1;
    s_wvalid  = 1'b1;
    while ((s_awvalid || s_wvalid) && cycles < TIMEOUT_CYCLES) begin
      aw_go = s_awvalid && s_awready;
      w_go  = s_wvalid && s_wready;
      @(negedge clk);
      cycles++;
      if (aw_go) s_awvalid = 1'b0;
      if (w_go) s_wvalid = 1'b0;
    end
    while (!s_bvalid && cycles < TIMEOUT_CYCLES) begin
      @(negedge clk);
      cycles++;
    end
    if (cycles >= TIMEOUT_CYCLES) begin
      timeout_count++;
      $display("timeout: AXI write to address %0d was not answered", addr);
      s_awvalid = 1'b0;
      s_wvalid  = 1'b0;
    end else begin
      check_value("s_bresp", s_bresp, cpu8_pkg::RESP_OKAY);
      // one write in flight, so both channels stay closed while B is pending
      check_value("s_awready while B pending", s_awready, 1'b0);
      check_value("s_wready while B pending", s_wready, 1'b0);
      // bready is held high, so B completes on the next edge
      @(negedge clk);
    end
  endtask

  task automatic load_program();
    run = 1'b0;
    for (int i = 0; i < `CPU8_PROG_DEPTH; i++) begin
      axi_write(4'(i), prog[i]);
    end
  endtask

  task automatic collect_out(output logic [7:0] value);
    int cycles;
    bit got;
    cycles = 0;
    got    = 1'b0;
    value  = '0;
    while (!got && cycles < TIMEOUT_CYCLES) begin
      @(negedge clk);
      cycles++;
      if (out_valid) begin
        value = out_data;
        got   = 1'b1;
      end
    end
    if (!got) begin
      timeout_count++;
      $display("timeout: no out_valid pulse within %0d cycles", TIMEOUT_CYCLES);
    end
  endtask

  task automatic expect_quiet(input int cycles, input string what);
    bit pulsed;
    pulsed = 1'b0;
    for (int i = 0; i < cycles; i++) begin
      @(negedge clk);
      if (out_valid && !pulsed) begin
        pulsed = 1'b1;
        error_count++;
        $display("error at %0t: %s", $time, what);
      end
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // directed tests
  ////////////////////////////////////////////////////////////////////////////

  task automatic test_nibble_out();
    logic [7:0] a;
    logic [7:0] b;
    logic [7:0] c;
    logic [7:0] v;
    reset_dut();
    a = 8'($urandom());
    b = 8'($urandom());
    c = 8'($urandom());
    place_byte_load(0, cpu8_pkg::OP_LDA_LO, cpu8_pkg::OP_LDA_HI, a);
    place_byte_load(2, cpu8_pkg::OP_LDB_LO, cpu8_pkg::OP_LDB_HI, b);
    place_byte_load(4, cpu8_pkg::OP_LDC_LO, cpu8_pkg::OP_LDC_HI, c);
    prog[6] = instr(cpu8_pkg::OP_OUT, cpu8_pkg::SEL_A);
    prog[7] = instr(cpu8_pkg::OP_OUT, cpu8_pkg::SEL_B);
    prog[8] = instr(cpu8_pkg::OP_OUT, cpu8_pkg::SEL_C);
    load_program();
    expect_quiet(20, "out_valid pulsed before run was raised");
    run = 1'b1;
    collect_out(v);
    check_value("out_data (A)", v, a);
    collect_out(v);
    check_value("out_data (B)", v, b);
    collect_out(v);
    check_value("out_data (C)", v, c);
    run = 1'b0;
  endtask

  task automatic test_arith();
    logic [7:0] a;
    logic [7:0] b;
    logic [7:0] v;
    logic [7:0] sum;
    logic [7:0] diff;
    logic [7:0] prod;
    reset_dut();
    a = 8'($urandom());
    b = 8'($urandom());
    sum  = a + b;
    diff = a - b;
    prod = a * b;
    place_byte_load(0, cpu8_pkg::OP_LDA_LO, cpu8_pkg::OP_LDA_HI, a);
    place_byte_load(2, cpu8_pkg::OP_LDB_LO, cpu8_pkg::OP_LDB_HI, b);
    prog[4] = instr(cpu8_pkg::OP_ADD, 4'd0);
    prog[5] = instr(cpu8_pkg::OP_OUT, cpu8_pkg::SEL_C);
    prog[6] = instr(cpu8_pkg::OP_SUB, 4'd0);
    prog[7] = instr(cpu8_pkg::OP_OUT, cpu8_pkg::SEL_C);
    prog[8] = instr(cpu8_pkg::OP_MUL, 4'd0);
    prog[9] = instr(cpu8_pkg::OP_OUT, cpu8_pkg::SEL_C);
    load_program();
    run = 1'b1;
    collect_out(v);
    check_value("out_data (ADD)", v, sum);
    collect_out(v);
    check_value("out_data (SUB)", v, diff);
    collect_out(v);
    check_value("out_data (MUL)", v, prod);
    run = 1'b0;
  endtask

  // bad selects and unused opcodes must leave A, B and C alone
  task automatic test_in();
    logic [7:0] v;
    reset_dut();
    in_data = 8'($urandom());
    place_byte_load(0, cpu8_pkg::OP_LDA_LO, cpu8_pkg::OP_LDA_HI, 8'($urandom()));
    place_byte_load(2, cpu8_pkg::OP_LDC_LO, cpu8_pkg::OP_LDC_HI, 8'($urandom()));
    prog[4]  = instr(cpu8_pkg::OP_IN, cpu8_pkg::SEL_B);
    prog[5]  = instr(cpu8_pkg::OP_OUT, cpu8_pkg::SEL_B);
    // B moves away from in_data so a stray IN into B would show
    place_byte_load(6, cpu8_pkg::OP_LDB_LO, cpu8_pkg::OP_LDB_HI, ~in_data);
    prog[8]  = instr(cpu8_pkg::OP_IN, 4'($urandom_range(15, 3)));
    prog[9]  = instr(cpu8_pkg::OP_OUT, 4'($urandom_range(15, 3)));
    prog[10] = instr(4'($urandom_range(15, 12)), 4'($urandom_range(15, 0)));
    prog[11] = instr(cpu8_pkg::OP_OUT, cpu8_pkg::SEL_A);
    prog[12] = instr(cpu8_pkg::OP_OUT, cpu8_pkg::SEL_B);
    prog[13] = instr(cpu8_pkg::OP_OUT, cpu8_pkg::SEL_C);
    load_program();
    model_outputs(4);
    run = 1'b1;
    for (int i = 0; i < 4; i++) begin
      collect_out(v);
      check_value($sformatf("out_data[%0d] (IN test)", i), v, exp_q[i]);
    end
    run = 1'b0;
  endtask

  task automatic test_wrap_run();
    logic [7:0] v;
    reset_dut();
    place_byte_load(0, cpu8_pkg::OP_LDA_LO, cpu8_pkg::OP_LDA_HI, 8'($urandom()));
    place_byte_load(2, cpu8_pkg::OP_LDB_LO, cpu8_pkg::OP_LDB_HI, 8'($urandom()));
    prog[4]  = instr(cpu8_pkg::OP_ADD, 4'd0);
    prog[15] = instr(cpu8_pkg::OP_OUT, cpu8_pkg::SEL_C);
    load_program();
    model_outputs(4);
    run = 1'b1;
    for (int i = 0; i < 3; i++) begin
      collect_out(v);
      check_value($sformatf("out_data[%0d] (pass)", i), v, exp_q[i]);
    end
    run = 1'b0;
    // let an instruction in flight drain first
    repeat (4) @(negedge clk);
    expect_quiet(80, "out_valid pulsed while run was low");
    run = 1'b1;
    collect_out(v);
    check_value("out_data (resumed)", v, exp_q[3]);
    run = 1'b0;
  endtask

  task automatic test_host_during_run();
    logic [7:0] a;
    logic [7:0] b;
    logic [7:0] v;
    bit         switched;
    reset_dut();
    a = 8'($urandom());
    b = a ^ 8'h5a;
    switched = 1'b0;
    place_byte_load(0, cpu8_pkg::OP_LDA_LO, cpu8_pkg::OP_LDA_HI, a);
    place_byte_load(2, cpu8_pkg::OP_LDB_LO, cpu8_pkg::OP_LDB_HI, b);
    prog[4] = instr(cpu8_pkg::OP_OUT, cpu8_pkg::SEL_A);
    load_program();
    run = 1'b1;
    collect_out(v);
    check_value("out_data (before rewrite)", v, a);
    axi_write(4'd10, instr(4'($urandom_range(15, 12)), 4'($urandom_range(15, 0))));
    axi_write(4'd4, instr(cpu8_pkg::OP_OUT, cpu8_pkg::SEL_B));
    // either value until the new byte is fetched, then only B
    for (int i = 0; i < 4; i++) begin
      collect_out(v);
      if (switched) begin
        check_value($sformatf("out_data[%0d] (after rewrite)", i), v, b);
      end else if (v === b) begin
        switched = 1'b1;
      end else begin
        check_value($sformatf("out_data[%0d] (old operand)", i), v, a);
      end
    end
    if (!switched) begin
      error_count++;
      $display("error: rewritten OUT operand never reached the output port");
    end
    run = 1'b0;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    void'($urandom(32'haa96));
    clk           = 1'b0;
    reset         = 1'b1;
    s_awvalid     = 1'b0;
    s_awaddr      = '0;
    s_wvalid      = 1'b0;
    s_wdata       = '0;
    s_bready      = 1'b1;
    run           = 1'b0;
    in_data       = '0;
    error_count   = 0;
    timeout_count = 0;

    test_nibble_out();
    test_arith();
    test_in();
    test_wrap_run();
    test_host_during_run();

    $display("errors: %0d check failures, %0d timeouts", error_count, timeout_count);
    if (error_count == 0 && timeout_count == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# build with Verilator, run, and judge the run from its log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -Wno-fatal --top-module tb_cpu8 -f cpu8.f -o tb_cpu8 \
  > sim.log 2>&1 \
  && ./obj_dir/tb_cpu8 >> sim.log 2>&1 \
  || echo "build or simulation stopped with an error"
grep -q "TESTBENCH PASSED" sim.log \
  && { echo "simulation passed"; exit 0; } \
  || { echo "simulation failed, see sim.log"; exit 1; }

//--- src/axi_lite_prog_loader.sv
// AXI4-Lite write slave that turns host writes into program store writes
`default_nettype none

`include "cpu8_macros.svh"

module axi_lite_prog_loader (
  input  wire                          clk,
  input  wire                          reset,
  // write address channel
  input  wire                          s_awvalid,
  output logic                         s_awready,
  input  wire [`CPU8_AXI_ADDR_W-1:0]   s_awaddr,
  // write data channel
  input  wire                          s_wvalid,
  output logic                         s_wready,
  input  wire [`CPU8_DATA_W-1:0]       s_wdata,
  // write response channel
  output logic                         s_bvalid,
  input  wire                          s_bready,
  output cpu8_pkg::axi_resp_e          s_bresp,
  // program store write port
  output logic                         host_wr_req,
  output logic [`CPU8_PC_W-1:0]        host_wr_addr,
  output logic [`CPU8_DATA_W-1:0]      host_wr_data,
  input  wire                          host_wr_gnt
);

  logic                         aw_held;
  logic                         w_held;
  logic [`CPU8_AXI_ADDR_W-1:0]  addr_q;
  logic [`CPU8_DATA_W-1:0]      data_q;

  logic aw_fire;
  logic w_fire;
  logic b_fire;
  logic wr_fire;

  // each channel closes once its beat is held, both stay closed until B is done
  assign s_awready = ~aw_held & ~s_bvalid;
  assign s_wready  = ~w_held & ~s_bvalid;

  assign aw_fire = s_awvalid & s_awready;
  assign w_fire  = s_wvalid & s_wready;
  assign b_fire  = s_bvalid & s_bready;

  assign host_wr_req  = aw_held & w_held;
  assign host_wr_addr = addr_q;
  assign host_wr_data = data_q;
  assign wr_fire      = host_wr_req & host_wr_gnt;

  // every write lands in the store, so the response is always okay
  assign s_bresp = cpu8_pkg::RESP_OKAY;

  ////////////////////////////////////////////////////////////////////////////
  // beat capture
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (aw_fire) begin
      addr_q <= s_awaddr;
    end
    if (w_fire) begin
      data_q <= s_wdata;
    end
  end

  // flags and response, AW and W may arrive in either order
  always_ff @(posedge clk) begin
    if (reset) begin
      aw_held  <= 1'b0;
      w_held   <= 1'b0;
      s_bvalid <= 1'b0;
    end else begin
      if (aw_fire) begin
        aw_held <= 1'b1;
      end
      if (w_fire) begin
        w_held <= 1'b1;
      end
      if (wr_fire) begin
        aw_held  <= 1'b0;
        w_held   <= 1'b0;
        s_bvalid <= 1'b1;
      end else if (b_fire) begin
        s_bvalid <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

//--- src/cpu8_macros.svh
// shared widths and sizes for the cpu8 RTL and testbench, pulled in with `include
`ifndef CPU8_MACROS_SVH
`define CPU8_MACROS_SVH

// register, byte and port width
`define CPU8_DATA_W 8

// program counter and memory index width
`define CPU8_PC_W 4

// bytes of program store
`define CPU8_PROG_DEPTH 16

// instruction split: opcode in the upper nibble, operand in the lower
`define CPU8_OPC_W 4
`define CPU8_OPD_W 4

// one AXI write address per program byte
`define CPU8_AXI_ADDR_W 4

`endif

//--- src/cpu8_pkg.sv
// cpu8 types shared by the RTL and testbench, referenced as cpu8_pkg::name
`default_nettype none

`include "cpu8_macros.svh"

package cpu8_pkg;

  // upper nibble of an instruction byte, codes 12 to 15 behave as nop
  typedef enum logic [`CPU8_OPC_W-1:0] {
    OP_NOP    = 4'd0,
    OP_LDA_LO = 4'd1,
    OP_LDA_HI = 4'd2,
    OP_LDB_LO = 4'd3,
    OP_LDB_HI = 4'd4,
    OP_LDC_LO = 4'd5,
    OP_LDC_HI = 4'd6,
    OP_ADD    = 4'd7,
    OP_SUB    = 4'd8,
    OP_MUL    = 4'd9,
    OP_OUT    = 4'd10,
    OP_IN     = 4'd11
  } opcode_e;

  // operand of out and in, other values select nothing
  typedef enum logic [`CPU8_OPD_W-1:0] {
    SEL_A = 4'd0,
    SEL_B = 4'd1,
    SEL_C = 4'd2
  } reg_sel_e;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_FETCH,
    ST_EXECUTE
  } core_state_e;

  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_EXOKAY = 2'b01,
    RESP_SLVERR = 2'b10,
    RESP_DECERR = 2'b11
  } axi_resp_e;

endpackage

`default_nettype wire

//--- src/cpu8_top.sv
// cpu8 top level, ties the AXI loader, the core and the program store together
`default_nettype none

`include "cpu8_macros.svh"

module cpu8_top (
  input  wire                          clk,
  input  wire                          reset,
  // host AXI4-Lite write channels
  input  wire                          s_awvalid,
  output logic                         s_awready,
  input  wire [`CPU8_AXI_ADDR_W-1:0]   s_awaddr,
  input  wire                          s_wvalid,
  output logic                         s_wready,
  input  wire [`CPU8_DATA_W-1:0]       s_wdata,
  output logic                         s_bvalid,
  input  wire                          s_bready,
  output cpu8_pkg::axi_resp_e          s_bresp,
  // core control and io
  input  wire                          run,
  input  wire [`CPU8_DATA_W-1:0]       in_data,
  output logic [`CPU8_DATA_W-1:0]      out_data,
  output logic                         out_valid
);

  logic                    host_wr_req;
  logic [`CPU8_PC_W-1:0]   host_wr_addr;
  logic [`CPU8_DATA_W-1:0] host_wr_data;
  logic                    host_wr_gnt;

  logic                    fetch_req;
  logic [`CPU8_PC_W-1:0]   fetch_addr;
  logic                    fetch_gnt;
  logic [`CPU8_DATA_W-1:0] fetch_data;

  axi_lite_prog_loader u_loader (
    .clk          (clk),
    .reset        (reset),
    .s_awvalid    (s_awvalid),
    .s_awready    (s_awready),
    .s_awaddr     (s_awaddr),
    .s_wvalid     (s_wvalid),
    .s_wready     (s_wready),
    .s_wdata      (s_wdata),
    .s_bvalid     (s_bvalid),
    .s_bready     (s_bready),
    .s_bresp      (s_bresp),
    .host_wr_req  (host_wr_req),
    .host_wr_addr (host_wr_addr),
    .host_wr_data (host_wr_data),
    .host_wr_gnt  (host_wr_gnt)
  );

  cpu_core u_core (
    .clk        (clk),
    .reset      (reset),
    .run        (run),
    .fetch_req  (fetch_req),
    .fetch_addr (fetch_addr),
    .fetch_gnt  (fetch_gnt),
    .fetch_data (fetch_data),
    .in_data    (in_data),
    .out_data   (out_data),
    .out_valid  (out_valid)
  );

  program_ram u_ram (
    .clk          (clk),
    .reset        (reset),
    .host_wr_req  (host_wr_req),
    .host_wr_addr (host_wr_addr),
    .host_wr_data (host_wr_data),
    .host_wr_gnt  (host_wr_gnt),
    .fetch_req    (fetch_req),
    .fetch_addr   (fetch_addr),
    .fetch_gnt    (fetch_gnt),
    .fetch_data   (fetch_data)
  );

endmodule

`default_nettype wire

//--- src/cpu_core.sv
// cpu8 execution core: fetch/execute FSM, program counter, A/B/C registers and ALU
`default_nettype none

`include "cpu8_macros.svh"

module cpu_core (
  input  wire                     clk,
  input  wire                     reset,
  input  wire                     run,
  // fetch port to the program store
  output logic                    fetch_req,
  output logic [`CPU8_PC_W-1:0]   fetch_addr,
  input  wire                     fetch_gnt,
  input  wire [`CPU8_DATA_W-1:0]  fetch_data,
  // io ports
  input  wire [`CPU8_DATA_W-1:0]  in_data,
  output logic [`CPU8_DATA_W-1:0] out_data,
  output logic                    out_valid
);

  cpu8_pkg::core_state_e state_q;
  cpu8_pkg::core_state_e state_d;

  logic [`CPU8_PC_W-1:0]   pc_q;
  logic [`CPU8_DATA_W-1:0] reg_a;
  logic [`CPU8_DATA_W-1:0] reg_b;
  logic [`CPU8_DATA_W-1:0] reg_c;

  cpu8_pkg::opcode_e       opcode;
  cpu8_pkg::reg_sel_e      sel;
  logic [`CPU8_OPD_W-1:0]  operand;
  logic [`CPU8_DATA_W-1:0] alu_result;
  logic [`CPU8_DATA_W-1:0] sel_value;
  logic                    sel_valid;
  logic                    executing;

  ////////////////////////////////////////////////////////////////////////////
  // control FSM
  ////////////////////////////////////////////////////////////////////////////

  // no request unless run is high, a denied fetch just retries
  assign fetch_req  = (state_q == cpu8_pkg::ST_FETCH) & run;
  assign fetch_addr = pc_q;
  assign executing  = (state_q == cpu8_pkg::ST_EXECUTE);

  always_comb begin
    state_d = state_q;
    case (state_q)
      cpu8_pkg::ST_IDLE: begin
        if (run) begin
          state_d = cpu8_pkg::ST_FETCH;
        end
      end
      cpu8_pkg::ST_FETCH: begin
        if (!run) begin
          state_d = cpu8_pkg::ST_IDLE;
        end else if (fetch_gnt) begin
          state_d = cpu8_pkg::ST_EXECUTE;
        end
      end
      default: state_d = cpu8_pkg::ST_FETCH;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // decode and datapath
  ////////////////////////////////////////////////////////////////////////////

  // fetched byte is already registered by the store, decode it directly
  assign opcode  = cpu8_pkg::opcode_e'(fetch_data[`CPU8_DATA_W-1:`CPU8_OPD_W]);
  assign operand = fetch_data[`CPU8_OPD_W-1:0];
  assign sel     = cpu8_pkg::reg_sel_e'(operand);

  // results wrap modulo 256
  always_comb begin
    case (opcode)
      cpu8_pkg::OP_SUB: alu_result = reg_a - reg_b;
      cpu8_pkg::OP_MUL: alu_result = reg_a * reg_b;
      default:          alu_result = reg_a + reg_b;
    endcase
  end

  // register picked by out
  always_comb begin
    sel_valid = 1'b1;
    case (sel)
      cpu8_pkg::SEL_A: sel_value = reg_a;
      cpu8_pkg::SEL_B: sel_value = reg_b;
      cpu8_pkg::SEL_C: sel_value = reg_c;
      default: begin
        sel_value = '0;
        sel_valid = 1'b0;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state_q   <= cpu8_pkg::ST_IDLE;
      pc_q      <= '0;
      reg_a     <= '0;
      reg_b     <= '0;
      reg_c     <= '0;
      out_data  <= '0;
      out_valid <= 1'b0;
    end else begin
      state_q   <= state_d;
      out_valid <= 1'b0;
      if (executing) begin
        // wraps from 15 back to 0
        pc_q <= pc_q + 1'b1;
        case (opcode)
          cpu8_pkg::OP_LDA_LO: reg_a[`CPU8_OPD_W-1:0] <= operand;
          cpu8_pkg::OP_LDA_HI: reg_a[`CPU8_DATA_W-1:`CPU8_OPD_W] <= operand;
          cpu8_pkg::OP_LDB_LO: reg_b[`CPU8_OPD_W-1:0] <= operand;
          cpu8_pkg::OP_LDB_HI: reg_b[`CPU8_DATA_W-1:`CPU8_OPD_W] <= operand;
          cpu8_pkg::OP_LDC_LO: reg_c[`CPU8_OPD_W-1:0] <= operand;
          cpu8_pkg::OP_LDC_HI: reg_c[`CPU8_DATA_W-1:`CPU8_OPD_W] <= operand;
          cpu8_pkg::OP_ADD,
          cpu8_pkg::OP_SUB,
          cpu8_pkg::OP_MUL:    reg_c <= alu_result;
          cpu8_pkg::OP_OUT: begin
            if (sel_valid) begin
              out_data  <= sel_value;
              out_valid <= 1'b1;
            end
          end
          cpu8_pkg::OP_IN: begin
            case (sel)
              cpu8_pkg::SEL_A: reg_a <= in_data;
              cpu8_pkg::SEL_B: reg_b <= in_data;
              cpu8_pkg::SEL_C: reg_c <= in_data;
              default: ;
            endcase
          end
          // nop and the unused codes
          default: ;
        endcase
      end
    end
  end

endmodule

`default_nettype wire

//--- src/program_ram.sv
// 16-byte program store shared by the host loader and the core fetch port
`default_nettype none

`include "cpu8_macros.svh"

module program_ram (
  input  wire                     clk,
  input  wire                     reset,
  // host write port
  input  wire                     host_wr_req,
  input  wire [`CPU8_PC_W-1:0]    host_wr_addr,
  input  wire [`CPU8_DATA_W-1:0]  host_wr_data,
  output logic                    host_wr_gnt,
  // core fetch port
  input  wire                     fetch_req,
  input  wire [`CPU8_PC_W-1:0]    fetch_addr,
  output logic                    fetch_gnt,
  output logic [`CPU8_DATA_W-1:0] fetch_data
);

  logic [`CPU8_DATA_W-1:0] mem [0:`CPU8_PROG_DEPTH-1];

  logic host_wr_fire;
  logic fetch_fire;

  ////////////////////////////////////////////////////////////////////////////
  // arbitration
  ////////////////////////////////////////////////////////////////////////////

  // host always wins, a fetch waits while a write is pending
  assign host_wr_gnt = host_wr_req;
  assign fetch_gnt   = fetch_req & ~host_wr_req;

  assign host_wr_fire = host_wr_req & host_wr_gnt;
  assign fetch_fire   = fetch_req & fetch_gnt;

  ////////////////////////////////////////////////////////////////////////////
  // storage
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < `CPU8_PROG_DEPTH; i++) begin
        mem[i] <= '0;
      end
    end else if (host_wr_fire) begin
      mem[host_wr_addr] <= host_wr_data;
    end
  end

  // fetched byte shows up the cycle after the grant
  always_ff @(posedge clk) begin
    if (reset) begin
      fetch_data <= '0;
    end else if (fetch_fire) begin
      fetch_data <= mem[fetch_addr];
    end
  end

endmodule

`default_nettype wire
